/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam logic [xlen-1:0] reset_pc = '0;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        logic [4:0]      rd;
        alu_op_t         alu_op;
        logic            use_imm;
        logic            is_lui;
        logic            mem_read;
        logic            mem_write;
        logic            is_branch;
        logic            branch_ne;
        logic            regf_we;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] store_data;
        logic            mem_read;
        logic            mem_write;
        logic            regf_we;
    } ex_mem_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic            regf_we;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] load_data;
        logic            mem_read;
    } mem_wb_t;

    // rd and rd_wdata read zero when nothing is written
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] rd_wdata;
    } commit_t;

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    input  logic            br_taken,
    input  logic [xlen-1:0] br_target,
    output logic            imem_req,
    output logic [xlen-1:0] imem_addr,
    input  logic            imem_ack,
    input  logic [xlen-1:0] imem_rdata,
    output if_id_t          if_id_next
);

    typedef enum logic [1:0] {f_idle, f_wait_ack, f_wait_release} fetch_state_t;

    fetch_state_t    state;
    logic [xlen-1:0] pc;
    logic            squash;
    if_id_t          hold;

    // one-entry buffer feeds if_id directly
    assign if_id_next = hold;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= f_idle;
            pc         <= reset_pc;
            squash     <= 1'b0;
            imem_req   <= 1'b0;
            imem_addr  <= reset_pc;
            hold.valid <= 1'b0;
        end
        else
        begin
            if (advance || br_taken)
                hold.valid <= 1'b0;
            if (br_taken)
                pc <= br_target;
            case (state)
                f_idle:
                    if (!br_taken && (!hold.valid || advance))
                    begin
                        imem_req  <= 1'b1;
                        imem_addr <= pc;
                        state     <= f_wait_ack;
                    end
                f_wait_ack:
                begin
                    // redirect mid-request, the returning word is stale
                    if (br_taken)
                        squash <= 1'b1;
                    if (imem_ack)
                    begin
                        imem_req <= 1'b0;
                        squash   <= 1'b0;
                        state    <= f_wait_release;
                        if (!squash && !br_taken)
                        begin
                            hold.valid <= 1'b1;
                            hold.pc    <= imem_addr;
                            hold.inst  <= imem_rdata;
                            pc         <= imem_addr + 32'd4;
                        end
                    end
                end
                f_wait_release:
                    if (!imem_ack)
                        state <= f_idle;
                default:
                    state <= f_idle;
            endcase
        end
    end

    imem_req_after_release: assert property (
        @(posedge clk) disable iff (rst) $rose(imem_req) |-> !imem_ack
    );

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  if_id_t          if_id,
    input  logic            wb_we,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_value,
    output id_ex_t          id_ex_next
);

    logic [xlen-1:0] regs [reg_count];
    logic [31:0]     inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    alu_op_t         funct_op;

    assign inst   = if_id.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end
        else if (wb_we && wb_rd != 5'd0)
            regs[wb_rd] <= wb_value;
    end

    // x0 reads zero, a same-cycle writeback wins over the array
    assign rs1_val = (rs1 == 5'd0) ? '0 : (wb_we && wb_rd == rs1) ? wb_value : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : (wb_we && wb_rd == rs2) ? wb_value : regs[rs2];

    always_comb
    begin
        case (funct3)
            3'b000:  funct_op = (opcode == op_reg && inst[30]) ? alu_sub : alu_add;
            3'b001:  funct_op = alu_sll;
            3'b010:  funct_op = alu_slt;
            3'b100:  funct_op = alu_xor;
            3'b101:  funct_op = alu_srl;
            3'b110:  funct_op = alu_or;
            3'b111:  funct_op = alu_and;
            default: funct_op = alu_add;
        endcase
    end

    always_comb
    begin
        id_ex_next         = '0;
        id_ex_next.pc      = if_id.pc;
        id_ex_next.inst    = inst;
        id_ex_next.rs1     = rs1;
        id_ex_next.rs2     = rs2;
        id_ex_next.rs1_val = rs1_val;
        id_ex_next.rs2_val = rs2_val;
        id_ex_next.rd      = rd;
        id_ex_next.alu_op  = alu_add;
        // unknown opcodes leave valid low
        case (opcode)
            op_reg:
            begin
                id_ex_next.valid   = if_id.valid;
                id_ex_next.alu_op  = funct_op;
                id_ex_next.regf_we = 1'b1;
            end
            op_imm:
            begin
                id_ex_next.valid   = if_id.valid;
                id_ex_next.alu_op  = funct_op;
                id_ex_next.imm     = imm_i;
                id_ex_next.use_imm = 1'b1;
                id_ex_next.regf_we = 1'b1;
            end
            op_lui:
            begin
                id_ex_next.valid   = if_id.valid;
                id_ex_next.imm     = imm_u;
                id_ex_next.is_lui  = 1'b1;
                id_ex_next.regf_we = 1'b1;
            end
            op_load:
            begin
                id_ex_next.valid    = if_id.valid;
                id_ex_next.imm      = imm_i;
                id_ex_next.use_imm  = 1'b1;
                id_ex_next.mem_read = 1'b1;
                id_ex_next.regf_we  = 1'b1;
            end
            op_store:
            begin
                id_ex_next.valid     = if_id.valid;
                id_ex_next.imm       = imm_s;
                id_ex_next.use_imm   = 1'b1;
                id_ex_next.mem_write = 1'b1;
            end
            op_branch:
            begin
                // beq and bne only
                id_ex_next.valid     = if_id.valid && funct3[2:1] == 2'b00;
                id_ex_next.imm       = imm_b;
                id_ex_next.is_branch = 1'b1;
                id_ex_next.branch_ne = funct3[0];
            end
            default:
                id_ex_next.valid = 1'b0;
        endcase
        // writes to x0 are dropped here so nothing forwards from them
        if (rd == 5'd0)
            id_ex_next.regf_we = 1'b0;
    end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import cpu_pkg::*;
(
    input  id_ex_t          id_ex,
    input  logic [4:0]      fwd_mem_rd,
    input  logic            fwd_mem_we,
    input  logic [xlen-1:0] fwd_mem_value,
    input  logic            wb_we,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_value,
    output ex_mem_t         ex_mem_next,
    output logic            br_taken,
    output logic [xlen-1:0] br_target
);

    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic            equal;

    // memory stage is younger, so it wins over writeback
    always_comb
    begin
        if (fwd_mem_we && fwd_mem_rd == id_ex.rs1)
            src1 = fwd_mem_value;
        else if (wb_we && wb_rd == id_ex.rs1)
            src1 = wb_value;
        else
            src1 = id_ex.rs1_val;
    end

    always_comb
    begin
        if (fwd_mem_we && fwd_mem_rd == id_ex.rs2)
            src2 = fwd_mem_value;
        else if (wb_we && wb_rd == id_ex.rs2)
            src2 = wb_value;
        else
            src2 = id_ex.rs2_val;
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : src2;

    always_comb
    begin
        case (id_ex.alu_op)
            alu_add: alu_result = src1 + op_b;
            alu_sub: alu_result = src1 - op_b;
            alu_and: alu_result = src1 & op_b;
            alu_or:  alu_result = src1 | op_b;
            alu_xor: alu_result = src1 ^ op_b;
            alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(src1) < $signed(op_b)};
            alu_sll: alu_result = src1 << op_b[4:0];
            alu_srl: alu_result = src1 >> op_b[4:0];
            default: alu_result = src1 + op_b;
        endcase
    end

    // branch_ne inverts the equality test
    assign equal     = (src1 == src2);
    assign br_taken  = id_ex.valid && id_ex.is_branch && (equal != id_ex.branch_ne);
    assign br_target = id_ex.pc + id_ex.imm;

    always_comb
    begin
        ex_mem_next.valid      = id_ex.valid;
        ex_mem_next.pc         = id_ex.pc;
        ex_mem_next.rd         = id_ex.rd;
        ex_mem_next.alu_result = id_ex.is_lui ? id_ex.imm : alu_result;
        ex_mem_next.store_data = src2;
        ex_mem_next.mem_read   = id_ex.mem_read;
        ex_mem_next.mem_write  = id_ex.mem_write;
        ex_mem_next.regf_we    = id_ex.regf_we;
    end

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  ex_mem_t         ex_mem,
    output logic            dmem_req,
    output logic            dmem_we,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    input  logic            dmem_ack,
    input  logic [xlen-1:0] dmem_rdata,
    output logic            mem_busy,
    output mem_wb_t         mem_wb_next
);

    typedef enum logic [1:0] {m_idle, m_wait_ack, m_wait_release} mem_state_t;

    mem_state_t      state;
    logic            done;
    logic            mem_op;
    logic [xlen-1:0] load_q;

    assign mem_op     = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);
    assign mem_busy   = mem_op && !done;
    // ex_mem holds while busy, so these stay put during the request
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_we    = ex_mem.mem_write;
    assign dmem_wdata = ex_mem.store_data;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= m_idle;
            dmem_req <= 1'b0;
            done     <= 1'b0;
        end
        else
        begin
            // busy is low while done, so the entry moves on this edge
            if (done)
                done <= 1'b0;
            case (state)
                m_idle:
                    if (mem_busy)
                    begin
                        dmem_req <= 1'b1;
                        state    <= m_wait_ack;
                    end
                m_wait_ack:
                    if (dmem_ack)
                    begin
                        dmem_req <= 1'b0;
                        load_q   <= dmem_rdata;
                        done     <= 1'b1;
                        state    <= m_wait_release;
                    end
                m_wait_release:
                    if (!dmem_ack)
                        state <= m_idle;
                default:
                    state <= m_idle;
            endcase
        end
    end

    always_comb
    begin
        mem_wb_next.valid      = ex_mem.valid;
        mem_wb_next.pc         = ex_mem.pc;
        mem_wb_next.rd         = ex_mem.rd;
        mem_wb_next.regf_we    = ex_mem.regf_we;
        mem_wb_next.alu_result = ex_mem.alu_result;
        mem_wb_next.load_data  = load_q;
        mem_wb_next.mem_read   = ex_mem.mem_read;
    end

    dmem_addr_stable: assert property (
        @(posedge clk) disable iff (rst) dmem_req && $past(dmem_req) |-> $stable(dmem_addr)
    );

endmodule

`default_nettype wire

/* hdl/pipeline_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    output logic            imem_req,
    output logic [xlen-1:0] imem_addr,
    input  logic            imem_ack,
    input  logic [xlen-1:0] imem_rdata,
    output logic            dmem_req,
    output logic            dmem_we,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    input  logic            dmem_ack,
    input  logic [xlen-1:0] dmem_rdata,
    output logic            commit_valid,
    output commit_t         commit
);

    if_id_t          if_id_next;
    if_id_t          if_id;
    id_ex_t          id_ex_next;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem_next;
    ex_mem_t         ex_mem;
    mem_wb_t         mem_wb_next;
    mem_wb_t         mem_wb;
    logic            br_taken;
    logic [xlen-1:0] br_target;
    logic            mem_busy;
    logic            advance;
    logic            redirect;
    logic            load_use;
    logic            fetch_advance;
    logic            fwd_mem_we;
    logic            wb_fresh;
    logic            wb_we;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_value;

    assign advance  = !mem_busy;
    assign redirect = br_taken && advance;
    // load in execute whose rd the instruction in decode reads
    assign load_use = id_ex.valid && id_ex.mem_read && id_ex.regf_we && if_id.valid
        && (id_ex.rd == if_id.inst[19:15] || id_ex.rd == if_id.inst[24:20]);
    assign fetch_advance = advance && !load_use;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            if_id.valid  <= 1'b0;
            id_ex.valid  <= 1'b0;
            ex_mem.valid <= 1'b0;
            mem_wb.valid <= 1'b0;
            wb_fresh     <= 1'b0;
        end
        else
        begin
            wb_fresh <= advance;
            if (advance)
            begin
                ex_mem <= ex_mem_next;
                mem_wb <= mem_wb_next;
                if (redirect)
                begin
                    if_id.valid <= 1'b0;
                    id_ex.valid <= 1'b0;
                end
                else if (load_use)
                    id_ex.valid <= 1'b0;
                else
                begin
                    if_id <= if_id_next;
                    id_ex <= id_ex_next;
                end
            end
        end
    end

    // loads reach execute from writeback after the load-use stall
    assign fwd_mem_we = ex_mem.valid && ex_mem.regf_we && !ex_mem.mem_read;

    // writeback select
    assign wb_we    = mem_wb.valid && mem_wb.regf_we;
    assign wb_rd    = mem_wb.rd;
    assign wb_value = mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_result;

    assign commit_valid    = mem_wb.valid && wb_fresh;
    assign commit.pc       = mem_wb.pc;
    assign commit.rd       = wb_we ? mem_wb.rd : 5'd0;
    assign commit.rd_wdata = wb_we ? wb_value : '0;

    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .advance    (fetch_advance),
        .br_taken   (redirect),
        .br_target  (br_target),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .if_id_next (if_id_next)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .if_id      (if_id),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_value   (wb_value),
        .id_ex_next (id_ex_next)
    );

    execute_stage u_execute (
        .id_ex         (id_ex),
        .fwd_mem_rd    (ex_mem.rd),
        .fwd_mem_we    (fwd_mem_we),
        .fwd_mem_value (ex_mem.alu_result),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_value      (wb_value),
        .ex_mem_next   (ex_mem_next),
        .br_taken      (br_taken),
        .br_target     (br_target)
    );

    mem_stage u_mem (
        .clk         (clk),
        .rst         (rst),
        .ex_mem      (ex_mem),
        .dmem_req    (dmem_req),
        .dmem_we     (dmem_we),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_ack    (dmem_ack),
        .dmem_rdata  (dmem_rdata),
        .mem_busy    (mem_busy),
        .mem_wb_next (mem_wb_next)
    );

    // a stalled branch keeps its decision until it redirects
    branch_held_in_stall: assert property (
        @(posedge clk) disable iff (rst) br_taken && !advance |=> br_taken
    );

endmodule

`default_nettype wire

/* test/tb_pipeline_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_cpu
    import cpu_pkg::*;
();

    localparam logic [6:0] opc_imm  = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;

    logic            clk;
    logic            rst;
    logic            imem_req;
    logic [xlen-1:0] imem_addr;
    logic            imem_ack;
    logic [xlen-1:0] imem_rdata;
    logic            dmem_req;
    logic            dmem_we;
    logic [xlen-1:0] dmem_addr;
    logic [xlen-1:0] dmem_wdata;
    logic            dmem_ack;
    logic [xlen-1:0] dmem_rdata;
    logic            commit_valid;
    commit_t         commit;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];

    // one row per test with programs and commits packed back to back
    string       test_name [$];
    int          prog_start [$];
    int          prog_len [$];
    int          exp_start [$];
    int          exp_len [$];
    logic [31:0] prog_word [$];
    commit_t     exp_q [$];
    int          dinit_test [$];
    logic [5:0]  dinit_idx [$];
    logic [31:0] dinit_val [$];
    int          dcheck_test [$];
    logic [5:0]  dcheck_idx [$];
    logic [31:0] dcheck_val [$];

    int errors;
    int seen;
    int cur;
    int cycles;
    int limit;
    int imem_delay;
    int dmem_delay;
    logic imem_armed;
    logic dmem_armed;

    pipeline_cpu dut (
        .clk          (clk),
        .rst          (rst),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_ack     (imem_ack),
        .imem_rdata   (imem_rdata),
        .dmem_req     (dmem_req),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_ack     (dmem_ack),
        .dmem_rdata   (dmem_rdata),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // RV32I instruction encoders
    function automatic logic [31:0] r_word(int f3, int f7, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(logic [6:0] op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_word(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_word(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'b1100011};
    endfunction

    function automatic logic [31:0] u_word(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    task automatic begin_test(string name);
        test_name.push_back(name);
        prog_start.push_back(prog_word.size());
        prog_len.push_back(0);
        exp_start.push_back(exp_q.size());
        exp_len.push_back(0);
    endtask

    // instruction that must commit with the given write
    task automatic add_retired(logic [31:0] word, int rd, logic [31:0] data);
        commit_t c;
        int      t;
        t          = test_name.size() - 1;
        c.pc       = prog_len[t] * 4;
        c.rd       = rd[4:0];
        c.rd_wdata = data;
        exp_q.push_back(c);
        exp_len[t]++;
        prog_word.push_back(word);
        prog_len[t]++;
    endtask

    task automatic add_skipped(logic [31:0] word);
        prog_word.push_back(word);
        prog_len[test_name.size() - 1]++;
    endtask

    task automatic add_data(logic [5:0] idx, logic [31:0] init, logic [31:0] final_val);
        dinit_test.push_back(test_name.size() - 1);
        dinit_idx.push_back(idx);
        dinit_val.push_back(init);
        dcheck_test.push_back(test_name.size() - 1);
        dcheck_idx.push_back(idx);
        dcheck_val.push_back(final_val);
    endtask

    task automatic build_tables();
        begin_test("alu_imm");
        add_retired(u_word(1, 'h12345), 1, 32'h12345000);
        add_retired(i_word(opc_imm, 0, 2, 0, 7), 2, 32'h7);
        add_retired(i_word(opc_imm, 0, 3, 0, -3), 3, 32'hfffffffd);
        add_retired(r_word(0, 0, 4, 2, 3), 4, 32'h4);
        add_retired(r_word(0, 32, 5, 2, 3), 5, 32'ha);
        add_retired(r_word(7, 0, 6, 1, 3), 6, 32'h12345000);
        add_retired(r_word(6, 0, 7, 2, 1), 7, 32'h12345007);
        add_retired(r_word(4, 0, 8, 2, 3), 8, 32'hfffffffa);
        add_retired(r_word(2, 0, 9, 3, 2), 9, 32'h1);
        add_retired(r_word(1, 0, 10, 2, 2), 10, 32'h380);
        add_retired(r_word(5, 0, 11, 3, 2), 11, 32'h01ffffff);
        add_retired(i_word(opc_imm, 4, 12, 2, 'h0f0), 12, 32'hf7);
        add_retired(i_word(opc_imm, 2, 13, 2, -1), 13, 32'h0);
        add_retired(i_word(opc_imm, 1, 14, 2, 4), 14, 32'h70);
        add_retired(i_word(opc_imm, 5, 15, 1, 12), 15, 32'h12345);
        add_retired(i_word(opc_imm, 6, 16, 2, 'h100), 16, 32'h107);

        begin_test("forwarding");
        add_retired(i_word(opc_imm, 0, 1, 0, 5), 1, 32'd5);
        add_retired(i_word(opc_imm, 0, 2, 1, 3), 2, 32'd8);
        add_retired(r_word(0, 0, 3, 1, 2), 3, 32'd13);
        add_retired(r_word(0, 32, 4, 3, 1), 4, 32'd8);
        add_retired(r_word(0, 0, 5, 4, 4), 5, 32'd16);
        // x0 write is dropped and reads back as zero
        add_retired(i_word(opc_imm, 0, 0, 0, 9), 0, 32'd0);
        add_retired(r_word(0, 0, 6, 0, 5), 6, 32'd16);

        begin_test("load_use");
        add_data(6'd4, 32'h100, 32'h100);
        add_data(6'd16, 32'h5a5a0010, 32'd25);
        add_data(6'd17, 32'h5a5a0011, 32'h101);
        add_retired(i_word(opc_imm, 0, 1, 0, 'h40), 1, 32'h40);
        add_retired(i_word(opc_imm, 0, 2, 0, 25), 2, 32'd25);
        add_retired(s_word(2, 1, 0), 0, 32'd0);
        add_retired(i_word(opc_load, 2, 3, 1, 0), 3, 32'd25);
        add_retired(r_word(0, 0, 4, 3, 2), 4, 32'd50);
        add_retired(i_word(opc_load, 2, 5, 0, 16), 5, 32'h100);
        add_retired(i_word(opc_imm, 0, 6, 5, 1), 6, 32'h101);
        add_retired(s_word(6, 1, 4), 0, 32'd0);

        begin_test("branch");
        add_retired(i_word(opc_imm, 0, 1, 0, 1), 1, 32'd1);
        add_retired(i_word(opc_imm, 0, 2, 0, 1), 2, 32'd1);
        add_retired(b_word(0, 1, 2, 12), 0, 32'd0);
        add_skipped(i_word(opc_imm, 0, 3, 0, 99));
        add_skipped(i_word(opc_imm, 0, 4, 0, 99));
        add_retired(b_word(1, 1, 2, 8), 0, 32'd0);
        add_retired(i_word(opc_imm, 0, 5, 0, 7), 5, 32'd7);
        add_retired(b_word(0, 0, 0, 8), 0, 32'd0);
        add_skipped(i_word(opc_imm, 0, 6, 0, 1));
        add_retired(r_word(0, 0, 7, 5, 1), 7, 32'd8);
    endtask

    task automatic check_commit(string name, commit_t expected, commit_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %s: expected pc=%h rd=%0d data=%h, actual pc=%h rd=%0d data=%h",
                name, expected.pc, expected.rd, expected.rd_wdata,
                actual.pc, actual.rd, actual.rd_wdata);
        end
    endtask

    task automatic check_word(string name, logic [xlen-1:0] expected, logic [xlen-1:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic run_test(int t);
        logic [31:0] w;
        @(posedge clk);
        rst <= 1'b1;
        cur  = t;
        seen = 0;
        for (int i = 0; i < 64; i++)
        begin
            w = i;
            // unused words decode as an unknown opcode and never commit
            if (i < prog_len[t])
                imem[i[5:0]] = prog_word[prog_start[t] + i];
            else
                imem[i[5:0]] = {w[24:0], 7'h7f};
            dmem[i[5:0]] <= 32'h5a5a0000 ^ w;
        end
        for (int k = 0; k < dinit_test.size(); k++)
            if (dinit_test[k] == t)
                dmem[dinit_idx[k]] <= dinit_val[k];
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait (seen >= exp_len[t]);
        // drain so that stray commits and late stores show up
        repeat (20) @(posedge clk);
        for (int k = 0; k < dcheck_test.size(); k++)
            if (dcheck_test[k] == t)
                check_word(test_name[t], dcheck_val[k], dmem[dcheck_idx[k]]);
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            imem_ack   <= 1'b0;
            imem_armed <= 1'b0;
        end
        else if (imem_ack)
        begin
            if (!imem_req)
                imem_ack <= 1'b0;
        end
        else if (imem_req)
        begin
            if (!imem_armed)
            begin
                imem_armed <= 1'b1;
                imem_delay <= $urandom % 4;
            end
            else if (imem_delay == 0)
            begin
                imem_ack   <= 1'b1;
                imem_rdata <= imem[imem_addr[7:2]];
                imem_armed <= 1'b0;
            end
            else
                imem_delay <= imem_delay - 1;
        end
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            dmem_ack   <= 1'b0;
            dmem_armed <= 1'b0;
        end
        else if (dmem_ack)
        begin
            if (!dmem_req)
                dmem_ack <= 1'b0;
        end
        else if (dmem_req)
        begin
            if (!dmem_armed)
            begin
                dmem_armed <= 1'b1;
                dmem_delay <= $urandom % 4;
            end
            else if (dmem_delay == 0)
            begin
                dmem_ack   <= 1'b1;
                dmem_rdata <= dmem[dmem_addr[7:2]];
                dmem_armed <= 1'b0;
                if (dmem_we)
                    dmem[dmem_addr[7:2]] <= dmem_wdata;
            end
            else
                dmem_delay <= dmem_delay - 1;
        end
    end

    // commit monitor
    always @(posedge clk)
    begin
        if (!rst && commit_valid)
        begin
            if (seen < exp_len[cur])
                check_commit(test_name[cur], exp_q[exp_start[cur] + seen], commit);
            else
            begin
                errors++;
                $display("%s: unexpected commit at pc %h after all expected commits",
                    test_name[cur], commit.pc);
            end
            seen++;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (limit > 0 && cycles >= limit)
        begin
            $display("timeout in %s after %0d cycles with %0d commits seen",
                test_name[cur], cycles, seen);
            $display("Test failures found");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(1));
        rst        = 1'b1;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        errors     = 0;
        seen       = 0;
        cur        = 0;
        cycles     = 0;
        build_tables();
        limit = prog_word.size() * 40;
        for (int t = 0; t < test_name.size(); t++)
            run_test(t);
        $display("%0d errors", errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/pipeline_cpu.sv
test/tb_pipeline_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pipeline_cpu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
